//--- include/issue_cfg.svh
`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

// instruction queue entries, must be a power of two
`define ISSUE_IQ_DEPTH 8

// architectural register index
`define ISSUE_REG_W 5

// pc, ir, imm and control words
`define ISSUE_WORD_W 32

// exception argument carried along with the slot
`define ISSUE_EXCP_W 16

`endif

//--- rtl/uop_pkg.sv
`include "issue_cfg.svh"

package uop_pkg;

    // low four bits of the control word
    typedef enum logic [3:0] {
        op_alu         = 4'd0,
        op_br          = 4'd1,
        op_div         = 4'd2,
        op_priv        = 4'd3,
        op_mul         = 4'd4,
        op_dcache      = 4'd5,
        op_priv_dcache = 4'd6,
        op_rdcnt       = 4'd7,
        op_alu_br      = 4'd8,
        op_bl          = 4'd9
    } op_type_e;

    // one decoded instruction as it sits in the queue
    typedef struct packed {
        logic [`ISSUE_WORD_W-1:0] pc;
        logic [`ISSUE_WORD_W-1:0] ir;
        logic [`ISSUE_WORD_W-1:0] imm;
        logic [`ISSUE_WORD_W-1:0] control;
        logic [`ISSUE_REG_W-1:0]  rk;
        logic [`ISSUE_REG_W-1:0]  rj;
        logic [`ISSUE_REG_W-1:0]  rd;
        logic [`ISSUE_EXCP_W-1:0] excp_arg;
    } issue_slot_t;

    function automatic op_type_e slot_op(issue_slot_t s);
        return op_type_e'(s.control[3:0]);
    endfunction

    // result arrives later than the next cycle
    function automatic logic is_long_lat(op_type_e op);
        return op inside {op_div, op_mul, op_dcache};
    endfunction

    // pipe 0 has no csr, counter or memory path
    function automatic logic pipe0_capable(op_type_e op);
        return op inside {op_alu, op_br, op_div, op_mul, op_alu_br, op_bl};
    endfunction

endpackage

//--- rtl/hazard_pkg.sv
`include "issue_cfg.svh"

package hazard_pkg;

    // destination of a long-latency op issued last cycle
    typedef struct packed {
        logic                    long_lat;
        logic [`ISSUE_REG_W-1:0] rd;
    } pend_dest_t;

    typedef struct packed {
        logic       issue1;
        logic       issue0;
        logic [1:0] pop_cnt;
    } dispatch_t;

    // a branch also reads its rd field
    function automatic logic pend_hit(pend_dest_t p,
                                      logic [`ISSUE_REG_W-1:0] rk,
                                      logic [`ISSUE_REG_W-1:0] rj,
                                      logic [`ISSUE_REG_W-1:0] rd,
                                      logic is_br);
        return p.long_lat && (p.rd == rk || p.rd == rj || (is_br && p.rd == rd));
    endfunction

endpackage

//--- rtl/instr_queue.sv
`timescale 1ns/10ps
`include "issue_cfg.svh"

module instr_queue (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 flush,
    input  logic                 stall,
    input  logic                 push0,
    input  logic                 push1,
    input  uop_pkg::issue_slot_t slot_in0,
    input  uop_pkg::issue_slot_t slot_in1,
    input  logic [1:0]           pop_cnt,
    output uop_pkg::issue_slot_t head_old,
    output uop_pkg::issue_slot_t head_young,
    output logic                 have_old,
    output logic                 have_young,
    output logic                 room
);
    import uop_pkg::*;

    localparam int DEPTH = `ISSUE_IQ_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    issue_slot_t      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] push_n;
    logic [CNT_W-1:0] pop_n;

    assign push_n = CNT_W'(push0) + CNT_W'(push1);
    // nothing leaves the queue while the stage is stalled
    assign pop_n  = stall ? '0 : CNT_W'(pop_cnt);

    // slot_in1 always lands right behind slot_in0
    always_ff @(posedge clk) begin
        if (!flush) begin
            if (push0) begin
                mem[wr_ptr] <= slot_in0;
            end
            if (push1) begin
                mem[wr_ptr + PTR_W'(1)] <= slot_in1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + push_n[PTR_W-1:0];
            rd_ptr <= rd_ptr + pop_n[PTR_W-1:0];
            count  <= count + push_n - pop_n;
        end
    end

    // two oldest entries, pointer wraps on its own
    assign head_old   = mem[rd_ptr];
    assign head_young = mem[rd_ptr + PTR_W'(1)];

    assign have_old   = (count != '0);
    assign have_young = (count >= CNT_W'(2));
    // room for a full pair
    assign room       = (count <= CNT_W'(DEPTH - 2));

    // upstream must respect the room level
    a_push_needs_room: assert property (
        @(posedge clk) disable iff (!rstn)
        (push0 || push1) |-> room
    );

    // dispatcher never pops entries that are not there
    a_pop_within_count: assert property (
        @(posedge clk) disable iff (!rstn)
        !stall |-> (CNT_W'(pop_cnt) <= count)
    );

endmodule

//--- rtl/pending_dest_tracker.sv
`timescale 1ns/10ps

module pending_dest_tracker (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   flush,
    input  logic                   stall,
    input  logic                   issue1,
    input  logic                   issue0,
    input  uop_pkg::issue_slot_t   slot1,
    input  uop_pkg::issue_slot_t   slot0,
    output hazard_pkg::pend_dest_t pend1,
    output hazard_pkg::pend_dest_t pend0
);
    import uop_pkg::*;
    import hazard_pkg::*;

    // only a slot that really issued can leave a pending write
    function automatic pend_dest_t capture(logic issued, issue_slot_t s);
        pend_dest_t p;
        p.long_lat = issued && is_long_lat(slot_op(s));
        p.rd       = issued ? s.rd : '0;
        return p;
    endfunction

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pend1 <= '0;
            pend0 <= '0;
        end else if (flush) begin
            pend1 <= '0;
            pend0 <= '0;
        end else if (!stall) begin
            // lives exactly one cycle unless the stage stalls
            pend1 <= capture(issue1, slot1);
            pend0 <= capture(issue0, slot0);
        end
    end

endmodule

//--- rtl/dual_dispatcher.sv
`timescale 1ns/10ps

module dual_dispatcher (
    input  logic                   clk,
    input  logic                   rstn,
    input  uop_pkg::issue_slot_t   head_old,
    input  uop_pkg::issue_slot_t   head_young,
    input  logic                   have_old,
    input  logic                   have_young,
    input  hazard_pkg::pend_dest_t pend1,
    input  hazard_pkg::pend_dest_t pend0,
    output hazard_pkg::dispatch_t  decision
);
    import uop_pkg::*;
    import hazard_pkg::*;

    op_type_e op_old;
    op_type_e op_young;
    logic     old_blocked;
    logic     young_blocked;
    logic     pair_dep;
    logic     young_ok;
    logic     issue1;
    logic     issue0;

    assign op_old   = slot_op(head_old);
    assign op_young = slot_op(head_young);

    // waiting on a mul, div or dcache result from either pipe
    assign old_blocked =
        pend_hit(pend1, head_old.rk, head_old.rj, head_old.rd, op_old == op_br) ||
        pend_hit(pend0, head_old.rk, head_old.rj, head_old.rd, op_old == op_br);

    assign young_blocked =
        pend_hit(pend1, head_young.rk, head_young.rj, head_young.rd, op_young == op_br) ||
        pend_hit(pend0, head_young.rk, head_young.rj, head_young.rd, op_young == op_br);

    // a branch never writes and r0 is never a real destination
    assign pair_dep = (head_old.rd != '0) && (op_old != op_br) &&
                      ((head_old.rd == head_young.rk) ||
                       (head_old.rd == head_young.rj) ||
                       ((head_old.rd == head_young.rd) && (op_young == op_br)));

    assign young_ok = have_young && !pair_dep && pipe0_capable(op_young) && !young_blocked;

    // older goes to pipe 1
    assign issue1 = have_old && !old_blocked;
    // dual issue needs a free older as well as a fitting younger
    assign issue0 = have_old && !old_blocked && young_ok;

    always_comb begin
        decision.issue1  = issue1;
        decision.issue0  = issue0;
        // a younger that goes always takes the older with it
        decision.pop_cnt = issue0 ? 2'd2 : {1'b0, issue1};
    end

    // the younger cannot overtake the older
    a_pipe0_after_pipe1: assert property (
        @(posedge clk) disable iff (!rstn)
        decision.issue0 |-> decision.issue1
    );

    // queue must drop exactly what reached the pipes
    a_pop_matches_issue: assert property (
        @(posedge clk) disable iff (!rstn)
        decision.pop_cnt == ({1'b0, decision.issue1} + {1'b0, decision.issue0})
    );

endmodule

//--- rtl/issue_regs.sv
`timescale 1ns/10ps

module issue_regs (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  flush,
    input  logic                  stall,
    input  hazard_pkg::dispatch_t decision,
    input  uop_pkg::issue_slot_t  slot_old,
    input  uop_pkg::issue_slot_t  slot_young,
    output logic                  pipe1_valid,
    output logic                  pipe0_valid,
    output uop_pkg::issue_slot_t  pipe1_slot,
    output uop_pkg::issue_slot_t  pipe0_slot
);
    import uop_pkg::*;

    // index 1 is pipe 1 (older), index 0 is pipe 0 (younger)
    logic [1:0]  issue_in;
    issue_slot_t slot_in [2];
    logic [1:0]  valid_q;
    issue_slot_t slot_q  [2];

    assign issue_in   = {decision.issue1, decision.issue0};
    assign slot_in[1] = slot_old;
    assign slot_in[0] = slot_young;

    for (genvar i = 0; i < 2; i++) begin : g_pipe
        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                valid_q[i] <= 1'b0;
            end else if (flush) begin
                valid_q[i] <= 1'b0;
            end else if (!stall) begin
                valid_q[i] <= issue_in[i];
            end
        end

        always_ff @(posedge clk) begin
            if (!stall && issue_in[i]) begin
                slot_q[i] <= slot_in[i];
            end
        end
    end

    assign pipe1_valid = valid_q[1];
    assign pipe0_valid = valid_q[0];

    // an empty pipe presents an all-zero slot
    assign pipe1_slot  = valid_q[1] ? slot_q[1] : '0;
    assign pipe0_slot  = valid_q[0] ? slot_q[0] : '0;

endmodule

//--- rtl/issue_stage.sv
`timescale 1ns/10ps

module issue_stage (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 flush,
    input  logic                 stall,
    input  logic                 push0,
    input  logic                 push1,
    input  uop_pkg::issue_slot_t slot_in0,
    input  uop_pkg::issue_slot_t slot_in1,
    output logic                 room,
    output logic                 pipe1_valid,
    output uop_pkg::issue_slot_t pipe1_slot,
    output logic                 pipe0_valid,
    output uop_pkg::issue_slot_t pipe0_slot
);
    import uop_pkg::*;
    import hazard_pkg::*;

    issue_slot_t head_old;
    issue_slot_t head_young;
    logic        have_old;
    logic        have_young;
    pend_dest_t  pend1;
    pend_dest_t  pend0;
    dispatch_t   decision;

    instr_queue u_instr_queue (
        .clk        (clk),
        .rstn       (rstn),
        .flush      (flush),
        .stall      (stall),
        .push0      (push0),
        .push1      (push1),
        .slot_in0   (slot_in0),
        .slot_in1   (slot_in1),
        .pop_cnt    (decision.pop_cnt),
        .head_old   (head_old),
        .head_young (head_young),
        .have_old   (have_old),
        .have_young (have_young),
        .room       (room)
    );

    // records what the pipes were handed at this edge
    pending_dest_tracker u_pending_dest_tracker (
        .clk    (clk),
        .rstn   (rstn),
        .flush  (flush),
        .stall  (stall),
        .issue1 (decision.issue1),
        .issue0 (decision.issue0),
        .slot1  (head_old),
        .slot0  (head_young),
        .pend1  (pend1),
        .pend0  (pend0)
    );

    dual_dispatcher u_dual_dispatcher (
        .clk        (clk),
        .rstn       (rstn),
        .head_old   (head_old),
        .head_young (head_young),
        .have_old   (have_old),
        .have_young (have_young),
        .pend1      (pend1),
        .pend0      (pend0),
        .decision   (decision)
    );

    issue_regs u_issue_regs (
        .clk         (clk),
        .rstn        (rstn),
        .flush       (flush),
        .stall       (stall),
        .decision    (decision),
        .slot_old    (head_old),
        .slot_young  (head_young),
        .pipe1_valid (pipe1_valid),
        .pipe0_valid (pipe0_valid),
        .pipe1_slot  (pipe1_slot),
        .pipe0_slot  (pipe0_slot)
    );

endmodule

//--- verification/issue_stage_vectors.svh
`ifndef ISSUE_STAGE_VECTORS_SVH
`define ISSUE_STAGE_VECTORS_SVH

// columns: older push, younger push, stall, flush, then the ids expected on
// pipe 1 and pipe 0 and the room level two clock edges after the row is driven
// a push is {id, op, rd, rj, rk}, id 0 means no push or an empty pipe

typedef struct packed {
    int       id;
    op_type_e op;
    int       rd;
    int       rj;
    int       rk;
} uop_desc_t;

typedef struct packed {
    uop_desc_t u0;
    uop_desc_t u1;
    int        stall;
    int        flush;
    int        exp1;
    int        exp0;
    int        exp_room;
} vec_t;

localparam uop_desc_t NO_UOP = '{0, op_alu, 0, 0, 0};

localparam int VEC_N = 28;

localparam vec_t VECS [VEC_N] = '{
    // independent pairs, younger alu then younger mul
    '{'{1, op_alu, 1, 2, 3},      '{2, op_alu, 4, 5, 6},       0, 0, 1, 2, 1},
    '{'{3, op_alu, 7, 8, 9},      '{4, op_mul, 10, 11, 12},    0, 0, 3, 4, 1},
    '{NO_UOP,                     NO_UOP,                      0, 0, 0, 0, 1},
    // younger reads the older rd
    '{'{5, op_alu, 13, 1, 2},     '{6, op_alu, 14, 13, 3},     0, 0, 5, 0, 1},
    '{NO_UOP,                     NO_UOP,                      0, 0, 6, 0, 1},
    // younger dcache stays behind, 9 then waits one cycle on r18
    '{'{7, op_alu, 15, 16, 17},   '{8, op_dcache, 18, 19, 20}, 0, 0, 7, 0, 1},
    '{'{9, op_alu, 21, 18, 22},   '{10, op_alu, 23, 24, 25},   0, 0, 8, 0, 1},
    '{NO_UOP,                     NO_UOP,                      0, 0, 0, 0, 1},
    '{NO_UOP,                     NO_UOP,                      0, 0, 9, 10, 1},
    // mul on pipe 0, then a reader of r29
    '{'{11, op_alu, 26, 27, 28},  '{12, op_mul, 29, 30, 31},   0, 0, 11, 12, 1},
    '{'{13, op_alu, 1, 29, 2},    '{14, op_alu, 3, 4, 5},      0, 0, 0, 0, 1},
    '{NO_UOP,                     NO_UOP,                      0, 0, 13, 14, 1},
    // older rd of r0, then an older branch
    '{'{15, op_alu, 0, 1, 2},     '{16, op_alu, 5, 0, 0},      0, 0, 15, 16, 1},
    '{'{17, op_br, 6, 7, 8},      '{18, op_alu, 9, 6, 6},      0, 0, 17, 18, 1},
    // younger branch on the older rd, then a priv op as younger
    '{'{19, op_alu, 10, 11, 12},  '{20, op_br, 10, 13, 14},    0, 0, 19, 0, 1},
    '{'{21, op_priv, 15, 16, 17}, '{22, op_alu, 18, 19, 20},   0, 0, 20, 0, 1},
    '{NO_UOP,                     NO_UOP,                      0, 0, 21, 22, 1},
    '{NO_UOP,                     NO_UOP,                      0, 0, 0, 0, 1},
    // stall holds 23 and 24 while pushes fill the queue
    '{'{23, op_alu, 1, 2, 3},     '{24, op_alu, 4, 5, 6},      0, 0, 23, 24, 1},
    '{'{25, op_alu, 7, 8, 9},     '{26, op_alu, 10, 11, 12},   0, 0, 23, 24, 1},
    '{'{27, op_alu, 13, 14, 15},  '{28, op_alu, 16, 17, 18},   1, 0, 23, 24, 1},
    '{'{29, op_alu, 19, 20, 21},  '{30, op_alu, 22, 23, 24},   1, 0, 23, 24, 0},
    '{'{31, op_alu, 25, 26, 27},  '{32, op_alu, 28, 29, 30},   1, 0, 25, 26, 1},
    '{NO_UOP,                     NO_UOP,                      0, 0, 0, 0, 1},
    // flush drops 27 to 32
    '{NO_UOP,                     NO_UOP,                      0, 1, 0, 0, 1},
    '{'{33, op_alu, 1, 2, 3},     '{34, op_alu, 4, 5, 6},      0, 0, 33, 34, 1},
    '{NO_UOP,                     NO_UOP,                      0, 0, 0, 0, 1},
    '{NO_UOP,                     NO_UOP,                      0, 0, 0, 0, 1}
};

`endif

//--- verification/tb_issue_stage.sv
`timescale 1ns/10ps
`include "issue_cfg.svh"

module tb_issue_stage;
    import uop_pkg::*;

    `include "issue_stage_vectors.svh"

    localparam int RST_CYCLES  = 4;
    // rows, two drain cycles and reset fit well inside
    localparam int CYCLE_LIMIT = VEC_N + 20;

    logic        clk;
    logic        rstn;
    logic        flush;
    logic        stall;
    logic        push0;
    logic        push1;
    issue_slot_t slot_in0;
    issue_slot_t slot_in1;
    logic        room;
    logic        pipe1_valid;
    issue_slot_t pipe1_slot;
    logic        pipe0_valid;
    issue_slot_t pipe0_slot;

    // what was pushed under each id
    logic [31:0]             pc_of [256];
    logic [31:0]             ir_of [256];
    logic [`ISSUE_REG_W-1:0] rd_of [256];
    integer                  seed;
    int                      cycle_cnt = 0;

    issue_stage u_issue_stage (
        .clk         (clk),
        .rstn        (rstn),
        .flush       (flush),
        .stall       (stall),
        .push0       (push0),
        .push1       (push1),
        .slot_in0    (slot_in0),
        .slot_in1    (slot_in1),
        .room        (room),
        .pipe1_valid (pipe1_valid),
        .pipe1_slot  (pipe1_slot),
        .pipe0_valid (pipe0_valid),
        .pipe0_slot  (pipe0_slot)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: the vector table did not finish in %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    task automatic stop_on_failure();
        $display("TEST FAIL");
        $fatal(1, "stopping at the first failed check");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail %s: got %h expected %h at cycle %0d", name, got, exp, cycle_cnt);
            stop_on_failure();
        end
    endtask

    // low pc byte carries the id so every pushed slot is unique
    task automatic make_slot(input uop_desc_t u, output issue_slot_t s);
        logic [31:0] rnd;
        s         = '0;
        rnd       = $random(seed);
        s.pc      = {rnd[31:8], u.id[7:0]};
        s.ir      = $random(seed);
        s.control = `ISSUE_WORD_W'(u.op);
        s.rd      = u.rd[`ISSUE_REG_W-1:0];
        s.rj      = u.rj[`ISSUE_REG_W-1:0];
        s.rk      = u.rk[`ISSUE_REG_W-1:0];
        if (u.id != 0) begin
            pc_of[u.id[7:0]] = s.pc;
            ir_of[u.id[7:0]] = s.ir;
            rd_of[u.id[7:0]] = s.rd;
        end
    endtask

    // an empty pipe must present an all-zero slot
    task automatic check_row(input int r);
        vec_t                    v;
        logic [31:0]             exp_pc1;
        logic [31:0]             exp_pc0;
        logic [31:0]             exp_ir1;
        logic [31:0]             exp_ir0;
        logic [`ISSUE_REG_W-1:0] exp_rd1;
        logic [`ISSUE_REG_W-1:0] exp_rd0;
        v       = VECS[r];
        exp_pc1 = (v.exp1 != 0) ? pc_of[v.exp1[7:0]] : '0;
        exp_ir1 = (v.exp1 != 0) ? ir_of[v.exp1[7:0]] : '0;
        exp_rd1 = (v.exp1 != 0) ? rd_of[v.exp1[7:0]] : '0;
        exp_pc0 = (v.exp0 != 0) ? pc_of[v.exp0[7:0]] : '0;
        exp_ir0 = (v.exp0 != 0) ? ir_of[v.exp0[7:0]] : '0;
        exp_rd0 = (v.exp0 != 0) ? rd_of[v.exp0[7:0]] : '0;
        compare_value("pipe1_valid", 32'(pipe1_valid), 32'(v.exp1 != 0));
        compare_value("pipe1_slot.pc", pipe1_slot.pc, exp_pc1);
        compare_value("pipe1_slot.ir", pipe1_slot.ir, exp_ir1);
        compare_value("pipe1_slot.rd", 32'(pipe1_slot.rd), 32'(exp_rd1));
        compare_value("pipe0_valid", 32'(pipe0_valid), 32'(v.exp0 != 0));
        compare_value("pipe0_slot.pc", pipe0_slot.pc, exp_pc0);
        compare_value("pipe0_slot.ir", pipe0_slot.ir, exp_ir0);
        compare_value("pipe0_slot.rd", 32'(pipe0_slot.rd), 32'(exp_rd0));
        compare_value("room", 32'(room), 32'(v.exp_room));
    endtask

    // first cycles out of reset
    task automatic expect_idle();
        compare_value("pipe1_valid", 32'(pipe1_valid), 32'd0);
        compare_value("pipe0_valid", 32'(pipe0_valid), 32'd0);
        compare_value("room", 32'(room), 32'd1);
    endtask

    initial begin
        int          r;
        vec_t        v;
        issue_slot_t s0;
        issue_slot_t s1;
        seed     = 89219;
        rstn     = 1'b0;
        flush    = 1'b0;
        stall    = 1'b0;
        push0    = 1'b0;
        push1    = 1'b0;
        slot_in0 = '0;
        slot_in1 = '0;
        repeat (RST_CYCLES) @(posedge clk);
        rstn <= 1'b1;

        // a row shows up on the pipes two edges after it is driven
        for (r = 0; r < VEC_N + 2; r++) begin
            @(posedge clk);
            if (r < VEC_N) begin
                v = VECS[r];
            end else begin
                v = '0;
            end
            make_slot(v.u0, s0);
            make_slot(v.u1, s1);
            push0    <= (v.u0.id != 0);
            push1    <= (v.u1.id != 0);
            slot_in0 <= s0;
            slot_in1 <= s1;
            stall    <= (v.stall != 0);
            flush    <= (v.flush != 0);
            @(negedge clk);
            if (r >= 2) begin
                check_row(r - 2);
            end else begin
                expect_idle();
            end
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

//--- files.f
+incdir+include
+incdir+verification
rtl/uop_pkg.sv
rtl/hazard_pkg.sv
rtl/instr_queue.sv
rtl/pending_dest_tracker.sv
rtl/dual_dispatcher.sv
rtl/issue_regs.sv
rtl/issue_stage.sv
verification/tb_issue_stage.sv

//--- Bender.yml
package:
  name: issue_stage

sources:
  - include_dirs:
      - include
    files:
      - rtl/uop_pkg.sv
      - rtl/hazard_pkg.sv
      - rtl/instr_queue.sv
      - rtl/pending_dest_tracker.sv
      - rtl/dual_dispatcher.sv
      - rtl/issue_regs.sv
      - rtl/issue_stage.sv
  - target: test
    include_dirs:
      - include
      - verification
    files:
      - verification/tb_issue_stage.sv
